// ==== verilog.f ====
+incdir+src
src/macRegsPkg.sv
src/operandBank.sv
src/operandSelect.sv
src/resultBank.sv
src/busReadMux.sv
src/macRegFile.sv
verif/macRegFileTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the MAC register file testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ps -f verilog.f --top-module macRegFileTb \
  -o macRegFileSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

simOutput=$(./obj_dir/macRegFileSim 2>&1)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if echo "$simOutput" | grep -qx "Verification passed"; then
  exit 0
fi
exit 1

// ==== verif/macRegFileTb.sv ====
// Testbench for the MAC register file
// Random stimulus from an xorshift generator, checked against a behavioral model

`timescale 1ns/1ps

`include "macRegs_config.svh"

module macRegFileTb;

  localparam int RESET_CYCLES   = 16;
  localparam int RUN_CYCLES     = 4000;
  // Some margin past the last stimulus cycle
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + RUN_CYCLES + 84;

  logic                  DSPCLK;
  logic                  reset;
  logic                  advance;
  logic                  shadow;
  logic                  accPm;
  logic                  dualFetch;
  macRegsPkg::dataWordT  dmdIn;
  macRegsPkg::dataWordT  pmdIn;
  macRegsPkg::macResultT macIn;
  macRegsPkg::bankWriteT xWrite0;
  macRegsPkg::bankWriteT xWrite1;
  macRegsPkg::bankWriteT yWrite0;
  macRegsPkg::bankWriteT yWrite1;
  macRegsPkg::opCtrlT    opCtrl;
  macRegsPkg::mrCtrlT    mrCtrl;
  macRegsPkg::readSelT   readSel;
  macRegsPkg::rStoreT    rStore;
  macRegsPkg::dataWordT  mxOp;
  macRegsPkg::dataWordT  myOp;
  macRegsPkg::mrT        mrOut;
  macRegsPkg::ovfWordT   mrOvf;
  macRegsPkg::dataWordT  dmdMac;
  macRegsPkg::dataWordT  pmdMac;
  macRegsPkg::dataWordT  rMac;

  // Model state is indexed [bank][register] and bank 1 is the secondary copy
  macRegsPkg::dataWordT  mxBank [2][2];
  macRegsPkg::dataWordT  myBank [2][2];
  macRegsPkg::mrT        mrBank [2];
  macRegsPkg::dataWordT  mfBank [2];
  macRegsPkg::ovfWordT   ovfModel;
  macRegsPkg::dataWordT  mxOpModel;
  macRegsPkg::dataWordT  myOpModel;

  logic [31:0] rngState     = 32'haf8f_aa75;
  bit          modelReady   = 1'b0;
  int          timeoutCount = 0;

  macRegFile uut (.DSPCLK, .reset, .advance, .shadow, .accPm, .dualFetch, .dmdIn, .pmdIn,
                  .macIn, .xWrite0, .xWrite1, .yWrite0, .yWrite1, .opCtrl, .mrCtrl,
                  .readSel, .rStore, .mxOp, .myOp, .mrOut, .mrOvf, .dmdMac, .pmdMac, .rMac);

  always #10 DSPCLK = ~DSPCLK;

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  task automatic nextRandom(output logic [31:0] value);
    rngState = xorshift32(rngState);
    value    = rngState;
  endtask

  // **************************************************************************
  // Stimulus
  // **************************************************************************

  task automatic driveRandomInputs();
    logic [31:0] r;
    logic [31:0] macLo;
    logic [2:0]  readIdx;
    logic [1:0]  storeIdx;
    nextRandom(r);
    dmdIn <= r[15:0];
    pmdIn <= r[31:16];
    nextRandom(macLo);
    nextRandom(r);
    macIn <= {r[7:0], macLo};
    nextRandom(r);
    advance   <= (r[2:0] != 3'b000);
    shadow    <= (r[5:3] == 3'b000) ? ~shadow : shadow;
    accPm     <= r[6];
    dualFetch <= r[7];
    // Bank strobes fire about one cycle in four
    xWrite0   <= {r[9:8] == 2'b00, r[11:10] == 2'b00};
    xWrite1   <= {r[13:12] == 2'b00, r[15:14] == 2'b00};
    yWrite0   <= {r[17:16] == 2'b00, r[19:18] == 2'b00};
    yWrite1   <= {r[21:20] == 2'b00, r[23:22] == 2'b00};
    nextRandom(r);
    opCtrl <= {r[0], r[1], r[2], r[3], r[5:4] == 2'b00, r[8:6] == 3'b000};
    mrCtrl <= {r[11:9] == 3'b000, r[14:12] == 3'b000, r[17:15] == 3'b000,
               r[19:18] == 2'b00, r[21:20] == 2'b00, r[23:22] == 2'b00};
    // Index 7 selects no register, index 3 stores nothing
    readIdx  = r[26:24];
    storeIdx = r[28:27];
    readSel <= {(readIdx != 3'd7) ? (7'b1000000 >> readIdx) : 7'b0000000, r[29], r[30]};
    rStore  <= (storeIdx != 2'd3) ? (3'b100 >> storeIdx) : 3'b000;
  endtask

  // **************************************************************************
  // Reference model
  // **************************************************************************

  task automatic stepModel();
    logic [39:0]          macRaw;
    macRegsPkg::dataWordT xBus;
    macRegsPkg::dataWordT yBus;
    macRegsPkg::dataWordT xPick;
    macRegsPkg::dataWordT yPick;
    macRegsPkg::mrT       mrNew;
    logic                 b;
    macRaw = macIn;
    xBus   = accPm ? pmdIn : dmdIn;
    yBus   = (accPm || dualFetch) ? pmdIn : dmdIn;
    b      = shadow;
    if (reset)
    begin
      for (int i = 0; i < 2; i++)
      begin
        for (int j = 0; j < 2; j++)
        begin
          mxBank[i][j] = '0;
          myBank[i][j] = '0;
        end
        mrBank[i] = '0;
        mfBank[i] = '0;
      end
      ovfModel  = '0;
      mxOpModel = '0;
      myOpModel = '0;
    end
    else if (advance)
    begin
      // Operands see the registers as they stood before this edge
      xPick = mxBank[b][opCtrl.xSel];
      yPick = opCtrl.zeroY ? '0 : opCtrl.square ? xPick :
              opCtrl.yFromMy ? myBank[b][opCtrl.ySel] : mfBank[b];
      mxOpModel = opCtrl.load ? xPick : mxOpModel;
      myOpModel = opCtrl.load ? yPick : myOpModel;

      // Later assignments win, so the lowest priority comes first
      mrNew     = mrBank[b];
      mrNew.mr0 = mrCtrl.mtMr0 ? xBus : mrNew.mr0;
      mrNew.mr2 = mrCtrl.mtMr2 ? xBus[7:0] : mrNew.mr2;
      mrNew.mr2 = mrCtrl.mtMr1 ? {8{xBus[15]}} : mrNew.mr2;
      mrNew.mr1 = mrCtrl.mtMr1 ? xBus : mrNew.mr1;
      if (mrCtrl.saturate)
        mrNew = mrBank[b].mr2[7] ? `MAC_SAT_NEG : `MAC_SAT_POS;
      if (mrCtrl.macWrite)
        mrNew = macRaw;
      mrBank[b] = mrNew;
      mfBank[b] = mrCtrl.mfWrite ? macRaw[31:16] : mfBank[b];
      ovfModel  = (mrCtrl.macWrite || mrCtrl.mfWrite) ? macRaw[39:31] : ovfModel;

      mxBank[0][0] = xWrite0.primary ? xBus : mxBank[0][0];
      mxBank[1][0] = xWrite0.secondary ? xBus : mxBank[1][0];
      mxBank[0][1] = xWrite1.primary ? xBus : mxBank[0][1];
      mxBank[1][1] = xWrite1.secondary ? xBus : mxBank[1][1];
      myBank[0][0] = yWrite0.primary ? yBus : myBank[0][0];
      myBank[1][0] = yWrite0.secondary ? yBus : myBank[1][0];
      myBank[0][1] = yWrite1.primary ? yBus : myBank[0][1];
      myBank[1][1] = yWrite1.secondary ? yBus : myBank[1][1];
    end
  endtask

  // **************************************************************************
  // Checks
  // **************************************************************************

  task automatic checkWord(input string name, input macRegsPkg::dataWordT got,
                           input macRegsPkg::dataWordT exp);
    if (got !== exp)
      abortRun($sformatf("[ERROR] time %0t: %s expected %h, got %h", $time, name, exp, got));
  endtask

  task automatic checkMr(input macRegsPkg::mrT got, input macRegsPkg::mrT exp);
    if (got !== exp)
      abortRun($sformatf("[ERROR] time %0t: mrOut expected %h_%h_%h, got %h_%h_%h", $time,
                         exp.mr2, exp.mr1, exp.mr0, got.mr2, got.mr1, got.mr0));
  endtask

  task automatic checkOvf(input macRegsPkg::ovfWordT got, input macRegsPkg::ovfWordT exp);
    if (got !== exp)
      abortRun($sformatf("[ERROR] time %0t: mrOvf expected %h, got %h", $time, exp, got));
  endtask

  task automatic checkOutputs();
    macRegsPkg::mrT       mrAct;
    macRegsPkg::dataWordT mr2Ext;
    macRegsPkg::dataWordT readWord;
    macRegsPkg::dataWordT rWord;
    logic                 b;
    b        = shadow;
    mrAct    = mrBank[b];
    mr2Ext   = {{8{mrAct.mr2[7]}}, mrAct.mr2};
    readWord = (readSel.mx0 ? mxBank[b][0] : '0) | (readSel.mx1 ? mxBank[b][1] : '0)
             | (readSel.my0 ? myBank[b][0] : '0) | (readSel.my1 ? myBank[b][1] : '0)
             | (readSel.mr0 ? mrAct.mr0 : '0) | (readSel.mr1 ? mrAct.mr1 : '0)
             | (readSel.mr2 ? mr2Ext : '0);
    rWord    = (rStore.mr0 ? mrAct.mr0 : '0) | (rStore.mr1 ? mrAct.mr1 : '0)
             | (rStore.mr2 ? mr2Ext : '0);
    checkWord("mxOp", mxOp, mxOpModel);
    checkWord("myOp", myOp, myOpModel);
    checkMr(mrOut, mrAct);
    checkOvf(mrOvf, ovfModel);
    checkWord("dmdMac", dmdMac, readSel.dmd ? readWord : '0);
    checkWord("pmdMac", pmdMac, readSel.pmd ? readWord : '0);
    checkWord("rMac", rMac, rWord);
  endtask

  always @(posedge DSPCLK)
  begin
    stepModel();
    modelReady = 1'b1;
  end

  // Outputs are settled at the falling edge
  always @(negedge DSPCLK)
  begin
    if (modelReady)
      checkOutputs();
  end

  always @(posedge DSPCLK)
  begin
    timeoutCount <= timeoutCount + 1;
    if (timeoutCount >= TIMEOUT_CYCLES)
      abortRun($sformatf("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES));
  end

  initial
  begin
    DSPCLK    = 1'b0;
    reset     = 1'b1;
    advance   = 1'b0;
    shadow    = 1'b0;
    accPm     = 1'b0;
    dualFetch = 1'b0;
    dmdIn     = '0;
    pmdIn     = '0;
    macIn     = '0;
    xWrite0   = '0;
    xWrite1   = '0;
    yWrite0   = '0;
    yWrite1   = '0;
    opCtrl    = '0;
    mrCtrl    = '0;
    readSel   = '0;
    rStore    = '0;
    repeat (RESET_CYCLES) @(posedge DSPCLK);
    reset <= 1'b0;
    for (int i = 0; i < RUN_CYCLES; i++)
    begin
      driveRandomInputs();
      @(posedge DSPCLK);
    end
    @(negedge DSPCLK);
    #1;
    $display("Verification passed");
    $finish;
  end

endmodule

// ==== src/macRegFile.sv ====
// MAC data register file
// Input registers, operand registers, MR/MF result bank and the bus read-back

`timescale 1ns/1ps

module macRegFile (
  input  logic                  DSPCLK,
  input  logic                  reset,
  input  logic                  advance,
  input  logic                  shadow,
  input  logic                  accPm,
  input  logic                  dualFetch,
  input  macRegsPkg::dataWordT  dmdIn,
  input  macRegsPkg::dataWordT  pmdIn,
  input  macRegsPkg::macResultT macIn,
  input  macRegsPkg::bankWriteT xWrite0,
  input  macRegsPkg::bankWriteT xWrite1,
  input  macRegsPkg::bankWriteT yWrite0,
  input  macRegsPkg::bankWriteT yWrite1,
  input  macRegsPkg::opCtrlT    opCtrl,
  input  macRegsPkg::mrCtrlT    mrCtrl,
  input  macRegsPkg::readSelT   readSel,
  input  macRegsPkg::rStoreT    rStore,
  output macRegsPkg::dataWordT  mxOp,
  output macRegsPkg::dataWordT  myOp,
  output macRegsPkg::mrT        mrOut,
  output macRegsPkg::ovfWordT   mrOvf,
  output macRegsPkg::dataWordT  dmdMac,
  output macRegsPkg::dataWordT  pmdMac,
  output macRegsPkg::dataWordT  rMac
);

  macRegsPkg::dataWordT xIn;
  macRegsPkg::dataWordT yIn;
  macRegsPkg::dataWordT mx0;
  macRegsPkg::dataWordT mx1;
  macRegsPkg::dataWordT my0;
  macRegsPkg::dataWordT my1;
  macRegsPkg::dataWordT mf;

  // Y fetches from program memory on a dual fetch as well
  assign xIn = accPm ? pmdIn : dmdIn;
  assign yIn = (accPm || dualFetch) ? pmdIn : dmdIn;

  operandBank xBank (.DSPCLK, .reset, .advance, .shadow, .busIn(xIn),
                     .write0(xWrite0), .write1(xWrite1), .reg0(mx0), .reg1(mx1));

  operandBank yBank (.DSPCLK, .reset, .advance, .shadow, .busIn(yIn),
                     .write0(yWrite0), .write1(yWrite1), .reg0(my0), .reg1(my1));

  operandSelect operandSelect (.DSPCLK, .reset, .advance, .mx0, .mx1, .my0, .my1, .mf,
                               .ctrl(opCtrl), .mxOp, .myOp);

  resultBank resultBank (.DSPCLK, .reset, .advance, .shadow, .macIn, .xIn,
                         .ctrl(mrCtrl), .mr(mrOut), .mf, .mrOvf);

  busReadMux busReadMux (.mx0, .mx1, .my0, .my1, .mr(mrOut), .readSel,
                         .store(rStore), .dmdMac, .pmdMac, .rMac);

endmodule

// ==== src/busReadMux.sv ====
// Register read-back onto the DMD and PMD buses, and MR stores onto the R bus
// MR2 is sign-extended to a full word on every path

`timescale 1ns/1ps

`include "macRegs_config.svh"

module busReadMux (
  input  macRegsPkg::dataWordT mx0,
  input  macRegsPkg::dataWordT mx1,
  input  macRegsPkg::dataWordT my0,
  input  macRegsPkg::dataWordT my1,
  input  macRegsPkg::mrT       mr,
  input  macRegsPkg::readSelT  readSel,
  input  macRegsPkg::rStoreT   store,
  output macRegsPkg::dataWordT dmdMac,
  output macRegsPkg::dataWordT pmdMac,
  output macRegsPkg::dataWordT rMac
);

  macRegsPkg::dataWordT mr2Ext;
  macRegsPkg::dataWordT readWord;

  assign mr2Ext = {{(`MAC_WORD_WIDTH-`MAC_MR2_WIDTH){mr.mr2[`MAC_MR2_WIDTH-1]}}, mr.mr2};

  // ************************************************************************
  // One-hot read select
  // ************************************************************************

  always_comb
  begin
    readWord = '0;
    if (readSel.mx0)
      readWord |= mx0;
    if (readSel.mx1)
      readWord |= mx1;
    if (readSel.my0)
      readWord |= my0;
    if (readSel.my1)
      readWord |= my1;
    if (readSel.mr0)
      readWord |= mr.mr0;
    if (readSel.mr1)
      readWord |= mr.mr1;
    if (readSel.mr2)
      readWord |= mr2Ext;
  end

  // Each bus sees the word only when its enable is up
  assign dmdMac = readSel.dmd ? readWord : '0;
  assign pmdMac = readSel.pmd ? readWord : '0;

  assign rMac = ({`MAC_WORD_WIDTH{store.mr0}} & mr.mr0)
              | ({`MAC_WORD_WIDTH{store.mr1}} & mr.mr1)
              | ({`MAC_WORD_WIDTH{store.mr2}} & mr2Ext);

endmodule

// ==== src/resultBank.sv ====
// MAC result registers MR0, MR1, MR2 and MF, each banked, plus the MRovf capture
// Handles MAC writes, saturation and bus transfers into the active bank

`timescale 1ns/1ps

`include "macRegs_config.svh"

module resultBank (
  input  logic                  DSPCLK,
  input  logic                  reset,
  input  logic                  advance,
  input  logic                  shadow,
  input  macRegsPkg::macResultT macIn,
  input  macRegsPkg::dataWordT  xIn,
  input  macRegsPkg::mrCtrlT    ctrl,
  output macRegsPkg::mrT        mr,
  output macRegsPkg::dataWordT  mf,
  output macRegsPkg::ovfWordT   mrOvf
);

  macRegsPkg::mrT       mrPri;
  macRegsPkg::mrT       mrSec;
  macRegsPkg::mrT       mrCur;
  macRegsPkg::mrT       mrNext;
  macRegsPkg::dataWordT mfPri;
  macRegsPkg::dataWordT mfSec;
  macRegsPkg::ovfWordT  ovfReg;
  logic                 mrUpdate;
  logic                 mrNegative;

  assign mrCur      = shadow ? mrSec : mrPri;
  assign mrNegative = mrCur.mr2[`MAC_MR2_WIDTH-1];

  assign mrUpdate = ctrl.macWrite | ctrl.saturate | ctrl.mtMr0 | ctrl.mtMr1 | ctrl.mtMr2;

  // ************************************************************************
  // Next value of the active MR bank
  // ************************************************************************

  always_comb
  begin
    mrNext = mrCur;
    if (ctrl.macWrite)
      mrNext = macIn.fields;
    else if (ctrl.saturate)
      mrNext = mrNegative ? macRegsPkg::mrT'(`MAC_SAT_NEG) : macRegsPkg::mrT'(`MAC_SAT_POS);
    else
    begin
      if (ctrl.mtMr0)
        mrNext.mr0 = xIn;

      // An MR1 load also fills MR2 with the sign of the new word
      if (ctrl.mtMr1)
      begin
        mrNext.mr1 = xIn;
        mrNext.mr2 = {`MAC_MR2_WIDTH{xIn[`MAC_WORD_WIDTH-1]}};
      end
      else if (ctrl.mtMr2)
        mrNext.mr2 = xIn[`MAC_MR2_WIDTH-1:0];
    end
  end

  // ************************************************************************
  // Banked registers
  // ************************************************************************

  always_ff @(posedge DSPCLK)
  begin
    if (reset)
    begin
      mrPri  <= '0;
      mrSec  <= '0;
      mfPri  <= '0;
      mfSec  <= '0;
      ovfReg <= '0;
    end
    else if (advance)
    begin
      if (mrUpdate)
      begin
        if (shadow)
          mrSec <= mrNext;
        else
          mrPri <= mrNext;
      end

      // MF takes result bits 31 to 16
      if (ctrl.mfWrite)
      begin
        if (shadow)
          mfSec <= macIn.fields.mr1;
        else
          mfPri <= macIn.fields.mr1;
      end

      if (ctrl.macWrite || ctrl.mfWrite)
        ovfReg <= macIn.ovfView.ovf;
    end
  end

  assign mr    = mrCur;
  assign mf    = shadow ? mfSec : mfPri;
  assign mrOvf = ovfReg;

endmodule

// ==== src/operandSelect.sv ====
// Multiplier operand selection
// Picks X from MX0 or MX1 and Y by priority, then holds both in operand registers

`timescale 1ns/1ps

module operandSelect (
  input  logic                 DSPCLK,
  input  logic                 reset,
  input  logic                 advance,
  input  macRegsPkg::dataWordT mx0,
  input  macRegsPkg::dataWordT mx1,
  input  macRegsPkg::dataWordT my0,
  input  macRegsPkg::dataWordT my1,
  input  macRegsPkg::dataWordT mf,
  input  macRegsPkg::opCtrlT   ctrl,
  output macRegsPkg::dataWordT mxOp,
  output macRegsPkg::dataWordT myOp
);

  macRegsPkg::dataWordT xPick;
  macRegsPkg::dataWordT myPick;
  macRegsPkg::dataWordT yPick;
  macRegsPkg::dataWordT mxOpReg;
  macRegsPkg::dataWordT myOpReg;

  // ************************************************************************
  // Operand choice
  // ************************************************************************

  always_comb
  begin
    xPick  = ctrl.xSel ? mx1 : mx0;
    myPick = ctrl.ySel ? my1 : my0;

    // Zero wins, then squaring, then MY over the MF feedback
    if (ctrl.zeroY)
      yPick = '0;
    else if (ctrl.square)
      yPick = xPick;
    else if (ctrl.yFromMy)
      yPick = myPick;
    else
      yPick = mf;
  end

  // ************************************************************************
  // Operand registers
  // ************************************************************************

  always_ff @(posedge DSPCLK)
  begin
    if (reset)
    begin
      mxOpReg <= '0;
      myOpReg <= '0;
    end
    else if (advance && ctrl.load)
    begin
      mxOpReg <= xPick;
      myOpReg <= yPick;
    end
  end

  // Operands stay put between loads
  assign mxOp = mxOpReg;
  assign myOp = myOpReg;

endmodule

// ==== src/operandBank.sv ====
// Banked input register pair for one multiplier side
// Each register has a primary and a secondary copy, written by its own strobes

`timescale 1ns/1ps

module operandBank (
  input  logic                  DSPCLK,
  input  logic                  reset,
  input  logic                  advance,
  input  logic                  shadow,
  input  macRegsPkg::dataWordT  busIn,
  input  macRegsPkg::bankWriteT write0,
  input  macRegsPkg::bankWriteT write1,
  output macRegsPkg::dataWordT  reg0,
  output macRegsPkg::dataWordT  reg1
);

  macRegsPkg::dataWordT  primBank [2];
  macRegsPkg::dataWordT  secBank  [2];
  macRegsPkg::bankWriteT strobe   [2];

  assign strobe[0] = write0;
  assign strobe[1] = write1;

  // ************************************************************************
  // Register copies
  // ************************************************************************

  always_ff @(posedge DSPCLK)
  begin
    if (reset)
    begin
      for (int i = 0; i < 2; i++)
      begin
        primBank[i] <= '0;
        secBank[i]  <= '0;
      end
    end
    else if (advance)
    begin
      // Strobes name the copy directly, so both copies may load at once
      for (int i = 0; i < 2; i++)
      begin
        if (strobe[i].primary)
          primBank[i] <= busIn;
        if (strobe[i].secondary)
          secBank[i] <= busIn;
      end
    end
  end

  // Active copies follow the shadow bank select
  assign reg0 = shadow ? secBank[0] : primBank[0];
  assign reg1 = shadow ? secBank[1] : primBank[1];

endmodule

// ==== src/macRegsPkg.sv ====
// MAC register file shared types
// Register words, the MAC result views and the control bundles

`include "macRegs_config.svh"

package macRegsPkg;

  typedef logic [`MAC_WORD_WIDTH-1:0] dataWordT;
  typedef logic [`MAC_MR2_WIDTH-1:0]  mr2WordT;
  typedef logic [`MAC_OVF_WIDTH-1:0]  ovfWordT;

  typedef struct packed {
    mr2WordT  mr2;
    dataWordT mr1;
    dataWordT mr0;
  } mrT;

  // Same result word seen as overflow bits over the rest
  typedef struct packed {
    ovfWordT                                     ovf;
    logic [`MAC_RESULT_WIDTH-`MAC_OVF_WIDTH-1:0] rest;
  } ovfViewT;

  typedef union packed {
    mrT      fields;
    ovfViewT ovfView;
  } macResultT;

  typedef struct packed {
    logic primary;
    logic secondary;
  } bankWriteT;

  typedef struct packed {
    logic load;
    logic xSel;
    logic ySel;
    logic yFromMy;
    logic square;
    logic zeroY;
  } opCtrlT;

  typedef struct packed {
    logic macWrite;
    logic mfWrite;
    logic saturate;
    logic mtMr0;
    logic mtMr1;
    logic mtMr2;
  } mrCtrlT;

  // One-hot register select plus the two bus drive enables
  typedef struct packed {
    logic mx0;
    logic mx1;
    logic my0;
    logic my1;
    logic mr0;
    logic mr1;
    logic mr2;
    logic dmd;
    logic pmd;
  } readSelT;

  typedef struct packed {
    logic mr0;
    logic mr1;
    logic mr2;
  } rStoreT;

endpackage

// ==== src/macRegs_config.svh ====
// MAC register file configuration
// Word widths of the data registers and the 40-bit saturation values

`ifndef MAC_REGS_CONFIG_SVH
`define MAC_REGS_CONFIG_SVH

// Bus and register word width
`define MAC_WORD_WIDTH 16

// MR2 is the 8-bit guard extension above MR1
`define MAC_MR2_WIDTH 8

// Full accumulator width of MR2:MR1:MR0
`define MAC_RESULT_WIDTH 40

// Overflow capture holds result bits 39 down to 31
`define MAC_OVF_WIDTH 9

// Largest positive and most negative 32-bit value, sign-extended to 40 bits
`define MAC_SAT_POS 40'h00_7FFF_FFFF
`define MAC_SAT_NEG 40'hFF_8000_0000

`endif
